// File: verilog.f
common/ps2_pkg.sv
src/ps2_line_sync.sv
src/ps2_timer.sv
tx/ps2_tx_shifter.sv
tx/ps2_tx_fsm.sv
rx/ps2_rx_shifter.sv
rx/ps2_rx_fsm.sv
src/ps2_host.sv
verif/tb_ps2_host.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ps2_host \
  -Mdir obj_dir -o tb_ps2_host > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_ps2_host > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "SIMULATION PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: verif/tb_ps2_host.sv
`timescale 1ns/1ns

module tb_ps2_host;
  import ps2_pkg::*;

  //////////////////////////////
  // run limits and codes
  //////////////////////////////

  // device clock half-period in design cycles
  localparam int half_period    = 40;
  localparam int inhibit_cycles = 2 ** ps2_inhibit_width;
  localparam int timeout_cycles = 2 ** ps2_timeout_width;
  localparam int frame_cycles   = 11 * 2 * half_period;
  localparam int n_tests        = 9;
  // per entry the inhibit plus one frame plus one receive timeout plus a gap
  localparam int cycle_limit    =
    n_tests * (inhibit_cycles + frame_cycles + timeout_cycles + 100) + 1000;

  localparam logic [1:0] fault_none   = 2'd0;
  localparam logic [1:0] fault_parity = 2'd1;
  localparam logic [1:0] fault_stop   = 2'd2;
  localparam logic [1:0] fault_clock  = 2'd3;

  typedef struct packed {
    ps2_byte_t  value;
    logic       from_dev;
    logic [1:0] fault;
  } test_vec_t;

  logic       clk;
  logic       rst;
  logic       wr_stb;
  ps2_byte_t  wr_data;
  ps2_drive_t ps2_drive;
  logic       tx_done;
  logic       tx_ready;
  logic       rd_valid;
  ps2_byte_t  rd_data;
  logic       rx_ready;
  // device side open-drain pulls
  logic       dev_clk_low;
  logic       dev_data_low;
  logic       ps2_clk_in;
  logic       ps2_data_in;

  test_vec_t  table_q [n_tests];
  int         err_cnt = 0;
  int         pass_cnt = 0;
  int         fail_cnt = 0;
  int         cycle_cnt = 0;
  int         tx_done_cnt = 0;
  int         rd_valid_cnt = 0;
  ps2_byte_t  valid_byte;

  // wired-AND of pull-ups, host requests and device
  assign ps2_clk_in  = ~(ps2_drive.clk_low | dev_clk_low);
  assign ps2_data_in = ~(ps2_drive.data_low | dev_data_low);

  ps2_host i_dut (
    .clk(clk), .rst(rst), .ps2_clk_in(ps2_clk_in), .ps2_data_in(ps2_data_in),
    .wr_stb(wr_stb), .wr_data(wr_data), .ps2_drive(ps2_drive), .tx_done(tx_done),
    .tx_ready(tx_ready), .rd_valid(rd_valid), .rd_data(rd_data), .rx_ready(rx_ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // pulse counters sample mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (!rst) begin
      if (tx_done) begin
        tx_done_cnt++;
      end
      if (rd_valid) begin
        rd_valid_cnt++;
        valid_byte = rd_data;
      end
    end
  end

  // run watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("error: simulation timed out after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string what);
    $display("error at %0t ns: %s", $time, what);
    err_cnt++;
  endtask

  // odd parity bit from the count of ones
  function automatic logic odd_parity(input ps2_byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < ps2_data_bits; i++) begin
      ones += int'(b[i]);
    end
    return (ones % 2 == 0);
  endfunction

  task automatic wait_ready(input logic rx_side, input int bound);
    int waited;
    waited = 0;
    while (!(rx_side ? rx_ready : tx_ready) && waited < bound) begin
      step();
      waited++;
    end
    if (!(rx_side ? rx_ready : tx_ready)) begin
      report_error($sformatf("%s stayed low for %0d cycles", rx_side ? "rx_ready" : "tx_ready",
                             bound));
    end
  endtask

  //////////////////////////////
  // device model
  //////////////////////////////

  // data changes while the clock is high and the host reads it on the fall
  task automatic device_bit(input logic b);
    dev_data_low = ~b;
    wait_cycles(half_period / 2);
    dev_clk_low = 1'b1;
    wait_cycles(half_period);
    dev_clk_low = 1'b0;
    wait_cycles(half_period / 2);
  endtask

  // n_bits below 11 stops the clock mid-frame
  task automatic device_send(input ps2_byte_t b, input logic [1:0] fault, input int n_bits);
    logic [10:0] frame;
    logic        par;
    logic        stop;
    par   = odd_parity(b) ^ (fault == fault_parity);
    stop  = (fault != fault_stop);
    frame = {stop, par, b, 1'b0};
    for (int i = 0; i < n_bits; i++) begin
      device_bit(frame[i]);
    end
    dev_data_low = 1'b0;
  endtask

  // device answers a host request with 11 clocks and reads before each rise
  task automatic host_send(input ps2_byte_t b);
    logic [10:0] got;
    int          low_cycles;
    int          done_before;
    done_before = tx_done_cnt;
    low_cycles  = 0;
    check_value("tx_ready", tx_ready, 1);
    wr_data = b;
    wr_stb  = 1'b1;
    step();
    wr_stb  = 1'b0;
    // both paths stay busy and data stays released during the inhibit phase
    while (ps2_drive.clk_low && low_cycles < inhibit_cycles + 100) begin
      check_value("tx_ready", tx_ready, 0);
      check_value("rx_ready", rx_ready, 0);
      check_value("ps2_drive.data_low", ps2_drive.data_low, 0);
      low_cycles++;
      step();
    end
    if (ps2_drive.clk_low) begin
      report_error("host never released the clock after the inhibit");
    end
    if (low_cycles < 8000) begin
      report_error($sformatf("clock inhibit lasted only %0d cycles", low_cycles));
    end
    // start bit
    check_value("ps2_drive.data_low", ps2_drive.data_low, 1);
    for (int k = 1; k <= 11; k++) begin
      // ack on the last clock
      if (k == 11) begin
        dev_data_low = 1'b1;
      end
      wait_cycles(half_period / 2);
      dev_clk_low = 1'b1;
      wait_cycles(half_period);
      got[k-1]    = ps2_data_in;
      dev_clk_low = 1'b0;
      wait_cycles(half_period / 2);
    end
    dev_data_low = 1'b0;
    wait_ready(1'b0, 100);
    check_value("host data bits", got[7:0], b);
    check_value("ones over data and parity odd", ^got[8:0], 1);
    check_value("host stop bit", got[9], 1);
    check_value("tx_done pulses", tx_done_cnt - done_before, 1);
  endtask

  task automatic device_test(input test_vec_t t);
    int valid_before;
    int waited;
    valid_before = rd_valid_cnt;
    waited       = 0;
    if (t.fault == fault_clock) begin
      device_send(t.value, fault_none, 5);
      check_value("rx_ready", rx_ready, 0);
      wait_ready(1'b1, timeout_cycles + 200);
      check_value("rd_valid pulses", rd_valid_cnt - valid_before, 0);
    end
    // clock loss entries follow up with a good frame
    device_send(t.value, (t.fault == fault_clock) ? fault_none : t.fault, 11);
    if (t.fault == fault_parity || t.fault == fault_stop) begin
      wait_ready(1'b1, 100);
      wait_cycles(4);
      check_value("rd_valid pulses", rd_valid_cnt - valid_before, 0);
    end else begin
      while (rd_valid_cnt == valid_before && waited < 100) begin
        step();
        waited++;
      end
      wait_cycles(4);
      check_value("rd_valid pulses", rd_valid_cnt - valid_before, 1);
      check_value("rd_data at rd_valid", valid_byte, t.value);
      check_value("rd_data", rd_data, t.value);
      check_value("rx_ready", rx_ready, 1);
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    int        seed;
    int        gap;
    int        err_before;
    test_vec_t t;
    rst          = 1'b1;
    wr_stb       = 1'b0;
    wr_data      = '0;
    dev_clk_low  = 1'b0;
    dev_data_low = 1'b0;
    seed         = $urandom(32'hc6b1);
    table_q[0] = '{value: 8'hed, from_dev: 1'b0, fault: fault_none};
    table_q[1] = '{value: 8'h00, from_dev: 1'b0, fault: fault_none};
    table_q[2] = '{value: 8'hf4, from_dev: 1'b1, fault: fault_none};
    table_q[3] = '{value: 8'h5a, from_dev: 1'b1, fault: fault_none};
    table_q[4] = '{value: 8'h3c, from_dev: 1'b1, fault: fault_parity};
    table_q[5] = '{value: 8'h81, from_dev: 1'b1, fault: fault_stop};
    table_q[6] = '{value: 8'h96, from_dev: 1'b1, fault: fault_clock};
    table_q[7] = '{value: 8'hff, from_dev: 1'b0, fault: fault_none};
    table_q[8] = '{value: 8'h01, from_dev: 1'b1, fault: fault_none};
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    // idle state after reset
    check_value("ps2_drive", ps2_drive, 0);
    check_value("tx_ready", tx_ready, 1);
    check_value("rx_ready", rx_ready, 1);
    check_value("tx_done", tx_done, 0);
    check_value("rd_valid", rd_valid, 0);
    for (int i = 0; i < n_tests; i++) begin
      t          = table_q[i];
      err_before = err_cnt;
      gap        = 10 + int'($urandom % 40);
      wait_cycles(gap);
      if (t.from_dev) begin
        device_test(t);
      end else begin
        host_send(t.value);
      end
      if (err_cnt == err_before) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("test %0d %s %02h: %s", i, t.from_dev ? "device send" : "host send", t.value,
               (err_cnt == err_before) ? "ok" : "failed");
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, pass_cnt, fail_cnt,
             err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: src/ps2_host.sv
`timescale 1ns/1ns

module ps2_host (
  input  logic                clk,
  input  logic                rst,
  input  logic                ps2_clk_in,
  input  logic                ps2_data_in,
  input  logic                wr_stb,
  input  ps2_pkg::ps2_byte_t  wr_data,
  output ps2_pkg::ps2_drive_t ps2_drive,
  output logic                tx_done,
  output logic                tx_ready,
  output logic                rd_valid,
  output ps2_pkg::ps2_byte_t  rd_data,
  output logic                rx_ready
);
  import ps2_pkg::*;

  ps2_line_t line;
  // send side
  logic      tx_load;
  logic      tx_shift;
  logic      tx_bit;
  logic      inh_load;
  logic      inh_run;
  logic      inh_expired;
  // receive side
  logic      rx_shift;
  logic      to_load;
  logic      to_expired;
  logic      frame_ok;

  //////////////////////////////
  // line input
  //////////////////////////////

  ps2_line_sync i_sync (
    .clk(clk), .rst(rst), .ps2_clk_in(ps2_clk_in), .ps2_data_in(ps2_data_in), .line(line)
  );

  //////////////////////////////
  // send path
  //////////////////////////////

  ps2_timer #(.width(ps2_inhibit_width)) i_inhibit (
    .clk(clk), .rst(rst), .load(inh_load), .run(inh_run), .expired(inh_expired)
  );

  ps2_tx_shifter i_tx_shifter (
    .clk(clk), .rst(rst), .load(tx_load), .shift(tx_shift), .data(wr_data), .bit_out(tx_bit)
  );

  ps2_tx_fsm i_tx_fsm (
    .clk(clk), .rst(rst), .line(line), .wr_stb(wr_stb), .inhibit_done(inh_expired),
    .bit_out(tx_bit), .drive(ps2_drive), .load(tx_load), .shift(tx_shift),
    .timer_load(inh_load), .timer_run(inh_run), .tx_done(tx_done), .tx_ready(tx_ready)
  );

  //////////////////////////////
  // receive path
  //////////////////////////////

  // watchdog counts down whenever it is not being reloaded
  ps2_timer #(.width(ps2_timeout_width)) i_timeout (
    .clk(clk), .rst(rst), .load(to_load), .run(~to_load), .expired(to_expired)
  );

  ps2_rx_shifter i_rx_shifter (
    .clk(clk), .rst(rst), .line(line), .shift(rx_shift), .rd_data(rd_data), .frame_ok(frame_ok)
  );

  // listens only while the send path is idle
  ps2_rx_fsm i_rx_fsm (
    .clk(clk), .rst(rst), .line(line), .rx_en(tx_ready), .timeout(to_expired),
    .frame_ok(frame_ok), .shift(rx_shift), .timer_load(to_load), .rd_valid(rd_valid),
    .rx_ready(rx_ready)
  );

endmodule

// File: rx/ps2_rx_fsm.sv
`timescale 1ns/1ns

module ps2_rx_fsm (
  input  logic               clk,
  input  logic               rst,
  input  ps2_pkg::ps2_line_t line,
  input  logic               rx_en,
  input  logic               timeout,
  input  logic               frame_ok,
  output logic               shift,
  output logic               timer_load,
  output logic               rd_valid,
  output logic               rx_ready
);
  import ps2_pkg::*;

  ps2_rx_state_t            state_q;
  ps2_rx_state_t            state_d;
  // edges left until the stop bit is in
  logic [ps2_cnt_width-1:0] cnt_q;
  logic [ps2_cnt_width-1:0] cnt_d;
  logic                     valid_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= rx_idle;
      cnt_q    <= '0;
      rd_valid <= 1'b0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      rd_valid <= valid_d;
    end
  end

  //////////////////////////////
  // frame sequencing
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    valid_d    = 1'b0;
    shift      = 1'b0;
    timer_load = 1'b0;
    rx_ready   = 1'b0;
    case (state_q)
      rx_idle: begin
        // ready only while the send path leaves the bus alone
        rx_ready = rx_en;
        // start bit is data low on a falling edge
        // enable drops while the host owns the bus
        if (rx_en && line.clk_fall && !line.data) begin
          cnt_d      = ps2_cnt_width'(ps2_rx_bits - 1);
          timer_load = 1'b1;
          state_d    = rx_data;
        end
      end
      rx_data: begin
        // device went quiet mid-frame so the frame is dropped
        if (timeout) begin
          state_d = rx_idle;
        end else if (line.clk_fall) begin
          shift      = 1'b1;
          // each bit restarts the watchdog
          timer_load = 1'b1;
          if (cnt_q == '0) begin
            state_d = rx_check;
          end else begin
            cnt_d = cnt_q - 1'b1;
          end
        end
      end
      rx_check: begin
        // shifter holds the full frame by now
        if (frame_ok) begin
          valid_d = 1'b1;
          state_d = rx_done;
        end else begin
          state_d = rx_idle;
        end
      end
      rx_done: state_d = rx_idle;
      default: state_d = rx_idle;
    endcase
  end

  // one pulse per frame
  rd_valid_single: assert property (
    @(posedge clk) disable iff (rst)
    rd_valid |=> !rd_valid
  );

endmodule

// File: rx/ps2_rx_shifter.sv
`timescale 1ns/1ns

module ps2_rx_shifter (
  input  logic               clk,
  input  logic               rst,
  input  ps2_pkg::ps2_line_t line,
  input  logic               shift,
  output ps2_pkg::ps2_byte_t rd_data,
  output logic               frame_ok
);
  import ps2_pkg::*;

  // {stop, parity, data}, lsb arrives first and ends up at bit 0
  logic [ps2_rx_bits-1:0] shreg;
  logic                   parity_ok;
  logic                   stop_ok;

  //////////////////////////////
  // capture
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      shreg <= '0;
    end else if (shift) begin
      // new bit enters at the top
      shreg <= {line.data, shreg[ps2_rx_bits-1:1]};
    end
  end

  // byte holds until the next frame starts shifting
  assign rd_data = shreg[ps2_data_bits-1:0];

  // odd parity over data plus parity bit
  assign parity_ok = ^shreg[ps2_data_bits:0];

  // stop must read high
  assign stop_ok = shreg[ps2_rx_bits-1];

  // only meaningful once all bits are in
  assign frame_ok = parity_ok & stop_ok;

endmodule

// File: tx/ps2_tx_fsm.sv
`timescale 1ns/1ns

module ps2_tx_fsm (
  input  logic                clk,
  input  logic                rst,
  input  ps2_pkg::ps2_line_t  line,
  input  logic                wr_stb,
  input  logic                inhibit_done,
  input  logic                bit_out,
  output ps2_pkg::ps2_drive_t drive,
  output logic                load,
  output logic                shift,
  output logic                timer_load,
  output logic                timer_run,
  output logic                tx_done,
  output logic                tx_ready
);
  import ps2_pkg::*;

  ps2_tx_state_t            state_q;
  ps2_tx_state_t            state_d;
  // counts remaining data and parity edges
  logic [ps2_cnt_width-1:0] cnt_q;
  logic [ps2_cnt_width-1:0] cnt_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= tx_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  //////////////////////////////
  // next state and line requests
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    drive      = '0;
    load       = 1'b0;
    shift      = 1'b0;
    timer_load = 1'b0;
    timer_run  = 1'b0;
    tx_done    = 1'b0;
    tx_ready   = 1'b0;
    case (state_q)
      tx_idle: begin
        tx_ready = 1'b1;
        // latch byte and arm the inhibit timer together
        if (wr_stb) begin
          load       = 1'b1;
          timer_load = 1'b1;
          state_d    = tx_inhibit;
        end
      end
      tx_inhibit: begin
        // hold clock low so the device abandons any transfer
        drive.clk_low = 1'b1;
        timer_run     = 1'b1;
        if (inhibit_done) begin
          state_d = tx_start;
        end
      end
      tx_start: begin
        // start bit while the device takes over clocking
        drive.data_low = 1'b1;
        if (line.clk_fall) begin
          cnt_d   = ps2_cnt_width'(ps2_tx_bits - 1);
          state_d = tx_data;
        end
      end
      tx_data: begin
        // lsb first and parity last
        drive.data_low = ~bit_out;
        if (line.clk_fall) begin
          shift = 1'b1;
          if (cnt_q == '0) begin
            state_d = tx_stop;
          end else begin
            cnt_d = cnt_q - 1'b1;
          end
        end
      end
      // released data lets the pull-up form the stop bit
      tx_stop: state_d = tx_ack;
      tx_ack: begin
        // device pulls data low around this edge
        if (line.clk_fall) begin
          tx_done = 1'b1;
          state_d = tx_wait_release;
        end
      end
      tx_wait_release: begin
        if (line.clk && line.data) begin
          state_d = tx_idle;
        end
      end
      default: state_d = tx_idle;
    endcase
  end

  // a new clock inhibit starts from a freshly loaded timer
  inhibit_starts_loaded: assert property (
    @(posedge clk) disable iff (rst)
    $rose(drive.clk_low) |-> !inhibit_done
  );

endmodule

// File: tx/ps2_tx_shifter.sv
`timescale 1ns/1ns

module ps2_tx_shifter (
  input  logic               clk,
  input  logic               rst,
  input  logic               load,
  input  logic               shift,
  input  ps2_pkg::ps2_byte_t data,
  output logic               bit_out
);
  import ps2_pkg::*;

  // {parity, data}, bit 0 is on the wire
  logic [ps2_tx_bits-1:0] shreg;
  logic                   parity;

  // odd parity, total count of ones comes out odd
  assign parity = ~(^data);

  //////////////////////////////
  // shift register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      // ones match a released line
      shreg <= '1;
    end else if (load) begin
      shreg <= {parity, data};
    end else if (shift) begin
      // fill with ones, line goes high once the frame is out
      shreg <= {1'b1, shreg[ps2_tx_bits-1:1]};
    end
  end

  assign bit_out = shreg[0];

endmodule

// File: src/ps2_timer.sv
`timescale 1ns/1ns

module ps2_timer #(
  parameter int width = ps2_pkg::ps2_timeout_width
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic run,
  output logic expired
);

  logic [width-1:0] count;

  //////////////////////////////
  // saturating down-counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      // zero after reset keeps expired low until the first load
      count <= '0;
    end else if (load) begin
      count <= '1;
    end else if (run && (count > width'(1))) begin
      // stops at one and holds there
      count <= count - width'(1);
    end
  end

  // level, stays up until the next load
  assign expired = (count == width'(1));

  // the owning fsm never loads and runs in the same cycle
  load_run_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(load && run)
  );

endmodule

// File: src/ps2_line_sync.sv
`timescale 1ns/1ns

module ps2_line_sync (
  input  logic               clk,
  input  logic               rst,
  input  logic               ps2_clk_in,
  input  logic               ps2_data_in,
  output ps2_pkg::ps2_line_t line
);

  // two-flop synchronizers, index 1 is the safe copy
  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  // previous synchronized clock level for edge detection
  logic       clk_prev;
  logic       fall_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      // idle bus is high, so start high to avoid a false edge
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
      fall_q    <= 1'b0;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk_in};
      data_sync <= {data_sync[0], ps2_data_in};
      clk_prev  <= clk_sync[1];
      // registered pulse, one cycle after the synced level drops
      fall_q    <= clk_prev & ~clk_sync[1];
    end
  end

  assign line = '{clk: clk_sync[1], data: data_sync[1], clk_fall: fall_q};

endmodule

// File: common/ps2_pkg.sv
package ps2_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  // payload bits in one frame
  localparam int ps2_data_bits = 8;
  // host send: data then parity, start and stop are handled by the fsm
  localparam int ps2_tx_bits = ps2_data_bits + 1;
  // device send: data, parity and stop after the start bit
  localparam int ps2_rx_bits = ps2_data_bits + 2;
  // bit counters in both fsms, wide enough for ps2_rx_bits - 1
  localparam int ps2_cnt_width = 4;

  // all ones gives roughly 100 us of clock inhibit
  localparam int ps2_inhibit_width = 13;
  // device clock loss detection
  localparam int ps2_timeout_width = 13;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [ps2_data_bits-1:0] ps2_byte_t;

  // synchronized line view
  typedef struct packed {
    logic clk;
    logic data;
    logic clk_fall;
  } ps2_line_t;

  // open-drain pull-low requests, the pad logic lives on the board side
  typedef struct packed {
    logic clk_low;
    logic data_low;
  } ps2_drive_t;

  typedef enum logic [2:0] {
    tx_idle         = 3'd0,
    tx_inhibit      = 3'd1,
    tx_start        = 3'd2,
    tx_data         = 3'd3,
    tx_stop         = 3'd4,
    tx_ack          = 3'd5,
    tx_wait_release = 3'd6
  } ps2_tx_state_t;

  typedef enum logic [1:0] {
    rx_idle  = 2'd0,
    rx_data  = 2'd1,
    rx_check = 2'd2,
    rx_done  = 2'd3
  } ps2_rx_state_t;

endpackage
